/* Makefile */
SIM             ?= verilator
TOP             ?= tb_alu
VERILATOR_FLAGS ?= --binary --timing -j 0
OBJ_DIR         ?= obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := alu_pkg.sv alu_adder.sv cond_eval.sv alu_logic_unit.sv \
        alu_flag_stage.sv alu_top.sv tb_alu.sv tb_alu_vectors.svh compile.f

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(SIM) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

/* alu_adder.sv */
// ==========================================================
// ALU adder
// 64-bit add/subtract split at 8/16/32 bit boundaries, gives
// carry or borrow and signed overflow per operand size
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module alu_adder import alu_pkg::*; (
  input  alu_op_e    op,
  input  word_t      a,
  input  word_t      b,
  output word_t      sum,
  output size_bits_t carry,
  output size_bits_t ovf,
  output logic       aux_carry
);

  logic       sub;
  word_t      bb;
  logic [8:0]  seg0;
  logic [8:0]  seg1;
  logic [16:0] seg2;
  logic [32:0] seg3;
  size_bits_t raw_carry;

  assign sub = (op == OP_SUB) || (op == OP_CMP);
  assign bb  = sub ? ~b : b; // two's complement, cin below

  // chained segments so every size boundary has its own carry out
  assign seg0 = {1'b0, a[7:0]}   + {1'b0, bb[7:0]}   + {8'b0, sub};
  assign seg1 = {1'b0, a[15:8]}  + {1'b0, bb[15:8]}  + {8'b0, seg0[8]};
  assign seg2 = {1'b0, a[31:16]} + {1'b0, bb[31:16]} + {16'b0, seg1[8]};
  assign seg3 = {1'b0, a[63:32]} + {1'b0, bb[63:32]} + {32'b0, seg2[16]};

  assign sum = {seg3[31:0], seg2[15:0], seg1[7:0], seg0[7:0]};

  assign raw_carry = {seg3[32], seg2[16], seg1[8], seg0[8]};

  // borrow is the inverted carry of a + ~b + 1
  assign carry = raw_carry ^ {4{sub}};

  // carry into bit 4 recovered from the sum bit
  assign aux_carry = a[4] ^ bb[4] ^ sum[4] ^ sub;

  // same operand signs, result sign differs
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      ovf[i] = (a[(8 << i) - 1] == bb[(8 << i) - 1]) &&
               (sum[(8 << i) - 1] != a[(8 << i) - 1]);
    end
  end

endmodule

`default_nettype wire

/* alu_flag_stage.sv */
// ==========================================================
// ALU flag stage
// result select and size merge, flag build, and the single
// output register stage of the ALU
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module alu_flag_stage import alu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  alu_op_e    op,
  input  op_size_e   size,
  input  word_t      a,
  input  word_t      sum,
  input  word_t      logic_result,
  input  size_bits_t carry,
  input  size_bits_t ovf,
  input  logic       aux_carry,
  input  flags_t     flags_in,
  output logic       out_valid,
  output logic       flags_we,
  output word_t      result,
  output flags_t     flags_out
);

  logic   is_arith;
  logic   is_bitwise;
  logic   is_sized;
  logic   sets_flags;
  word_t  raw;
  word_t  merged;
  word_t  flag_src;
  logic   sign_bit;
  logic   zero_bit;
  flags_t new_flags;

  assign is_arith   = (op == OP_ADD) || (op == OP_SUB) || (op == OP_CMP);
  assign is_bitwise = (op == OP_AND) || (op == OP_OR) || (op == OP_XOR) || (op == OP_XNOR);
  assign is_sized   = is_arith || is_bitwise || (op == OP_MOV) || (op == OP_CMOV);
  assign sets_flags = is_arith || is_bitwise;

  // cmp keeps a as result but takes its flags from the difference
  assign raw      = !is_arith ? logic_result : ((op == OP_CMP) ? a : sum);
  assign flag_src = is_arith ? sum : logic_result;

  always_comb
  begin
    merged = raw; // extensions and cset are always full width
    if (is_sized)
    begin
      case (size)
        SZ8:     merged = {a[WORD_W-1:8], raw[7:0]};
        SZ16:    merged = {a[WORD_W-1:16], raw[15:0]};
        SZ32:    merged = {{(WORD_W-32){1'b0}}, raw[31:0]};
        default: merged = raw;
      endcase
    end
  end

  always_comb
  begin
    case (size)
      SZ8:
      begin
        sign_bit = flag_src[7];
        zero_bit = (flag_src[7:0] == 8'b0);
      end
      SZ16:
      begin
        sign_bit = flag_src[15];
        zero_bit = (flag_src[15:0] == 16'b0);
      end
      SZ32:
      begin
        sign_bit = flag_src[31];
        zero_bit = (flag_src[31:0] == 32'b0);
      end
      default:
      begin
        sign_bit = flag_src[WORD_W-1];
        zero_bit = (flag_src == '0);
      end
    endcase
  end

  always_comb
  begin
    new_flags = '0; // C O A stay clear for bitwise ops
    if (is_arith)
    begin
      new_flags[FLAG_C] = carry[size];
      new_flags[FLAG_O] = ovf[size];
      new_flags[FLAG_A] = aux_carry;
    end
    new_flags[FLAG_S] = sign_bit;
    new_flags[FLAG_Z] = zero_bit;
    new_flags[FLAG_P] = ~^flag_src[7:0]; // even parity
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
      flags_we  <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end
    else
    begin
      out_valid <= in_valid;
      flags_we  <= in_valid && sets_flags;
      if (in_valid)
      begin
        result    <= merged;
        flags_out <= sets_flags ? new_flags : flags_in;
      end
    end
  end

endmodule

`default_nettype wire

/* alu_logic_unit.sv */
// ==========================================================
// ALU logic unit
// bitwise ops, moves, zero/sign extension, cmov and cset;
// full width values, size merge happens in the flag stage
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module alu_logic_unit import alu_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  logic    taken,
  output word_t   logic_result
);

  word_t val_and;
  word_t val_or;
  word_t val_xor;

  assign val_and = a & b;
  assign val_or  = a | b;
  assign val_xor = a ^ b;

  always_comb
  begin
    case (op)
      OP_AND:
      begin
        logic_result = val_and;
      end
      OP_OR:
      begin
        logic_result = val_or;
      end
      OP_XOR:
      begin
        logic_result = val_xor;
      end
      OP_XNOR:
      begin
        logic_result = ~val_xor;
      end
      OP_MOV:
      begin
        logic_result = b; // upper bits merged from a later
      end
      // extensions take the source from b
      OP_ZXT8:
      begin
        logic_result = {{(WORD_W-8){1'b0}}, b[7:0]};
      end
      OP_ZXT16:
      begin
        logic_result = {{(WORD_W-16){1'b0}}, b[15:0]};
      end
      OP_SXT8:
      begin
        logic_result = {{(WORD_W-8){b[7]}}, b[7:0]};
      end
      OP_SXT16:
      begin
        logic_result = {{(WORD_W-16){b[15]}}, b[15:0]};
      end
      OP_SXT32:
      begin
        logic_result = {{(WORD_W-32){b[31]}}, b[31:0]};
      end
      OP_CMOV:
      begin
        logic_result = taken ? b : a;
      end
      OP_CSET:
      begin
        logic_result = {{(WORD_W-1){1'b0}}, taken};
      end
      default:
      begin
        logic_result = '0; // arithmetic goes through the adder
      end
    endcase
  end

endmodule

`default_nettype wire

/* alu_pkg.sv */
// ==========================================================
// ALU package
// widths, word and flag types, operation, size and condition
// encodings shared by the integer ALU stage
// ==========================================================
`default_nettype none

package alu_pkg;

  localparam int WORD_W  = 64;
  localparam int FLAGS_W = 6;

  // flag bit positions, order C O A S Z P from the top
  localparam int FLAG_C = 5;
  localparam int FLAG_O = 4;
  localparam int FLAG_A = 3;
  localparam int FLAG_S = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_P = 0;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [FLAGS_W-1:0] flags_t;

  // one bit per size, bit 0 is 8 bit up to bit 3 for 64 bit
  typedef logic [3:0] size_bits_t;

  typedef enum logic [4:0] {
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_CMP   = 5'd2,
    OP_AND   = 5'd3,
    OP_OR    = 5'd4,
    OP_XOR   = 5'd5,
    OP_XNOR  = 5'd6,
    OP_MOV   = 5'd7,
    OP_ZXT8  = 5'd8,
    OP_ZXT16 = 5'd9,
    OP_SXT8  = 5'd10,
    OP_SXT16 = 5'd11,
    OP_SXT32 = 5'd12,
    OP_CMOV  = 5'd13,
    OP_CSET  = 5'd14
  } alu_op_e;

  // value doubles as index into size_bits_t
  typedef enum logic [1:0] {
    SZ8  = 2'd0,
    SZ16 = 2'd1,
    SZ32 = 2'd2,
    SZ64 = 2'd3
  } op_size_e;

  typedef enum logic [3:0] {
    CC_EQ  = 4'd0,
    CC_NE  = 4'd1,
    CC_S   = 4'd2,
    CC_NS  = 4'd3,
    CC_UGT = 4'd4,
    CC_ULE = 4'd5,
    CC_UGE = 4'd6,
    CC_ULT = 4'd7,
    CC_SGT = 4'd8,
    CC_SLE = 4'd9,
    CC_SGE = 4'd10,
    CC_SLT = 4'd11,
    CC_O   = 4'd12,
    CC_NO  = 4'd13,
    CC_P   = 4'd14,
    CC_AL  = 4'd15
  } cond_e;

endpackage

`default_nettype wire

/* alu_top.sv */
// ==========================================================
// ALU top
// single issue integer ALU, one cycle from in_valid to
// registered result and flags
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  alu_op_e  op,
  input  op_size_e size,
  input  cond_e    cond,
  input  word_t    a,
  input  word_t    b,
  input  flags_t   flags_in,
  output logic     out_valid,
  output word_t    result,
  output flags_t   flags_out,
  output logic     flags_we
);

  word_t      sum;
  size_bits_t carry;
  size_bits_t ovf;
  logic       aux_carry;
  logic       taken;
  word_t      logic_result;

  alu_adder i_adder (
    .op        (op),
    .a         (a),
    .b         (b),
    .sum       (sum),
    .carry     (carry),
    .ovf       (ovf),
    .aux_carry (aux_carry)
  );

  cond_eval i_cond (
    .flags_in (flags_in),
    .cond     (cond),
    .taken    (taken)
  );

  alu_logic_unit i_logic (
    .op           (op),
    .a            (a),
    .b            (b),
    .taken        (taken),
    .logic_result (logic_result)
  );

  alu_flag_stage i_flags (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .op           (op),
    .size         (size),
    .a            (a),
    .sum          (sum),
    .logic_result (logic_result),
    .carry        (carry),
    .ovf          (ovf),
    .aux_carry    (aux_carry),
    .flags_in     (flags_in),
    .out_valid    (out_valid),
    .flags_we     (flags_we),
    .result       (result),
    .flags_out    (flags_out)
  );

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
alu_pkg.sv
alu_adder.sv
cond_eval.sv
alu_logic_unit.sv
alu_flag_stage.sv
alu_top.sv
tb_alu.sv

/* cond_eval.sv */
// ==========================================================
// condition evaluator
// maps a 4-bit condition code onto the incoming flags
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cond_eval import alu_pkg::*; (
  input  flags_t flags_in,
  input  cond_e  cond,
  output logic   taken
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;

  assign c = flags_in[FLAG_C];
  assign o = flags_in[FLAG_O];
  assign s = flags_in[FLAG_S];
  assign z = flags_in[FLAG_Z];
  assign p = flags_in[FLAG_P];

  always_comb
  begin
    case (cond)
      CC_EQ:  taken = z;
      CC_NE:  taken = ~z;
      CC_S:   taken = s;
      CC_NS:  taken = ~s;
      CC_UGT: taken = ~c & ~z;
      CC_ULE: taken = c | z;
      CC_UGE: taken = ~c;
      CC_ULT: taken = c;
      CC_SGT: taken = (s == o) & ~z; // signed greater
      CC_SLE: taken = (s != o) | z;
      CC_SGE: taken = (s == o);
      CC_SLT: taken = (s != o);
      CC_O:   taken = o;
      CC_NO:  taken = ~o;
      CC_P:   taken = p;
      default: taken = 1'b1; // CC_AL
    endcase
  end

endmodule

`default_nettype wire

/* tb_alu_vectors.svh */
// ==========================================================
// ALU directed vectors
// rows of op, size, a, b, flags in and expected outputs,
// plus flag pairs that make each condition true and false
// ==========================================================
`ifndef TB_ALU_VECTORS_SVH
`define TB_ALU_VECTORS_SVH

// flag order C O A S Z P
localparam flags_t MOVE_FLAGS = 6'b101010;

task automatic fill_vectors();
  // arithmetic corners
  add_row(OP_ADD, SZ8,  64'h1111_1111_1111_11FF, 64'h1, 64'h1111_1111_1111_1100, 6'b101011, 1);
  add_row(OP_ADD, SZ8,  64'h7F, 64'h1, 64'h80, 6'b011100, 1); // signed overflow
  add_row(OP_SUB, SZ16, 64'hAAAA_AAAA_AAAA_0000, 64'h1, 64'hAAAA_AAAA_AAAA_FFFF, 6'b101101, 1);
  add_row(OP_SUB, SZ32, 64'hFFFF_FFFF_8000_0000, 64'h1, 64'h0000_0000_7FFF_FFFF, 6'b011001, 1);
  add_row(OP_CMP, SZ64, 64'h5, 64'h5, 64'h5, 6'b000011, 1);
  add_row(OP_CMP, SZ64, 64'h3, 64'h5, 64'h3, 6'b101100, 1); // borrow, result stays a
  add_row(OP_ADD, SZ64, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h0, 6'b101011, 1);
  add_row(OP_ADD, SZ16, 64'h1234_5678_0000_8000, 64'h8000, 64'h1234_5678_0000_0000,
          6'b110011, 1);
  // bitwise
  add_row(OP_AND,  SZ8,  64'hFFFF_FFFF_FFFF_FF0F, 64'hF3, 64'hFFFF_FFFF_FFFF_FF03, 6'b000001, 1);
  add_row(OP_OR,   SZ16, 64'h1111_1111_1111_0000, 64'h0, 64'h1111_1111_1111_0000, 6'b000011, 1);
  add_row(OP_XOR,  SZ32, 64'hFFFF_FFFF_F0F0_F0F0, 64'h0F0F_0F0E, 64'h0000_0000_FFFF_FFFE,
          6'b000100, 1);
  add_row(OP_XNOR, SZ64, 64'h0, 64'h0, 64'hFFFF_FFFF_FFFF_FFFF, 6'b000101, 1);
  // moves and extensions keep incoming flags
  add_row(OP_MOV,   SZ8,  64'hAAAA_AAAA_AAAA_AAAA, 64'h1234_5678_9ABC_DEF0,
          64'hAAAA_AAAA_AAAA_AAF0, MOVE_FLAGS, 0);
  add_row(OP_MOV,   SZ16, 64'hAAAA_AAAA_AAAA_AAAA, 64'h1234_5678_9ABC_DEF0,
          64'hAAAA_AAAA_AAAA_DEF0, MOVE_FLAGS, 0);
  add_row(OP_MOV,   SZ32, 64'hAAAA_AAAA_AAAA_AAAA, 64'h1234_5678_9ABC_DEF0,
          64'h0000_0000_9ABC_DEF0, MOVE_FLAGS, 0);
  add_row(OP_MOV,   SZ64, 64'hAAAA_AAAA_AAAA_AAAA, 64'h1234_5678_9ABC_DEF0,
          64'h1234_5678_9ABC_DEF0, MOVE_FLAGS, 0);
  add_row(OP_ZXT8,  SZ8,  64'h0, 64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_00F0, MOVE_FLAGS, 0);
  add_row(OP_SXT8,  SZ8,  64'h0, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_FFFF_FFFF_FFF0, MOVE_FLAGS, 0);
  add_row(OP_ZXT16, SZ8,  64'h0, 64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_DEF0, MOVE_FLAGS, 0);
  add_row(OP_SXT16, SZ16, 64'h0, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_FFFF_FFFF_DEF0, MOVE_FLAGS, 0);
  add_row(OP_SXT32, SZ8,  64'h0, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_FFFF_9ABC_DEF0, MOVE_FLAGS, 0);
endtask

// indexed by condition code, AL has no false case
localparam flags_t COND_TRUE [16] = '{
  6'b000010, 6'b000000, 6'b000100, 6'b000000,
  6'b000000, 6'b100000, 6'b000000, 6'b100000,
  6'b000000, 6'b000010, 6'b010100, 6'b000100,
  6'b010000, 6'b000000, 6'b000001, 6'b000000
};
localparam flags_t COND_FALSE [16] = '{
  6'b000000, 6'b000010, 6'b000000, 6'b000100,
  6'b100000, 6'b000000, 6'b100000, 6'b000000,
  6'b000010, 6'b000000, 6'b000100, 6'b010100,
  6'b000000, 6'b010000, 6'b000000, 6'b000000
};

`endif

/* tb_alu.sv */
// ==========================================================
// ALU testbench
// directed table, conditions, random add/sub and streaming
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_alu import alu_pkg::*; ();

  localparam int TIMEOUT = 20;

  typedef struct {
    alu_op_e  op;
    op_size_e size;
    word_t    a;
    word_t    b;
    flags_t   fin;
    word_t    exp_res;
    flags_t   exp_flags;
    logic     exp_we;
  } vec_t;

  logic     clk;
  logic     rst;
  logic     in_valid;
  alu_op_e  op;
  op_size_e size;
  cond_e    cond;
  word_t    a;
  word_t    b;
  flags_t   flags_in;
  logic     out_valid;
  word_t    result;
  flags_t   flags_out;
  logic     flags_we;
  vec_t     vec_q[$];

  alu_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .size      (size),
    .cond      (cond),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  `include "tb_alu_vectors.svh"

  task automatic add_row(alu_op_e o, op_size_e s, word_t x, word_t y, word_t er, flags_t ef,
                         logic ew);
    vec_t v;
    v.op = o;
    v.size = s;
    v.a = x;
    v.b = y;
    v.fin = ew ? 6'b0 : MOVE_FLAGS;
    v.exp_res = er;
    v.exp_flags = ef;
    v.exp_we = ew;
    vec_q.push_back(v);
  endtask

  task automatic report_error(string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp)
      report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_flags(flags_t got, flags_t exp, string what);
    if (got !== exp)
      report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp)
      report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // add/sub at operation size, built from the flag rules
  function automatic void arith_model(input alu_op_e o, input op_size_e s, input word_t x,
                                      input word_t y, output word_t r, output flags_t f);
    int n;
    word_t mask;
    logic [64:0] full;
    word_t sr;
    logic sa;
    logic sb;
    logic sres;
    n = 8 << s;
    mask = (n == 64) ? '1 : ((64'd1 << n) - 64'd1);
    if (o == OP_ADD)
      full = {1'b0, x & mask} + {1'b0, y & mask};
    else
      full = {1'b0, x & mask} - {1'b0, y & mask};
    sr = full[63:0] & mask;
    sa = x[n-1];
    sb = y[n-1];
    sres = sr[n-1];
    f[FLAG_C] = full[n]; // wraps into bit n on borrow too
    if (o == OP_ADD)
    begin
      f[FLAG_O] = (sa == sb) && (sres != sa);
      f[FLAG_A] = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
    end
    else
    begin
      f[FLAG_O] = (sa != sb) && (sres != sa);
      f[FLAG_A] = x[3:0] < y[3:0];
    end
    f[FLAG_S] = sres;
    f[FLAG_Z] = (sr == '0);
    f[FLAG_P] = ~^sr[7:0];
    case (s)
      SZ8:     r = {x[63:8], sr[7:0]};
      SZ16:    r = {x[63:16], sr[15:0]};
      default: r = sr;
    endcase
  endfunction

  task automatic wait_valid();
    int cycles;
    cycles = 0;
    while (out_valid !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("out_valid never rose within %0d cycles", TIMEOUT);
        $display("tests failed");
        $fatal(1, "timeout");
      end
    end
  endtask

  task automatic apply_vec(vec_t v, cond_e c, string tag);
    @(negedge clk);
    in_valid = 1'b1;
    op = v.op;
    size = v.size;
    cond = c;
    a = v.a;
    b = v.b;
    flags_in = v.fin;
    @(negedge clk);
    in_valid = 1'b0;
    wait_valid();
    check_word(result, v.exp_res, {tag, " result"});
    check_flags(flags_out, v.exp_flags, {tag, " flags"});
    check_bit(flags_we, v.exp_we, {tag, " flags_we"});
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    vec_t v;
    vec_t burst[8];
    logic tk;
    void'($urandom(15));
    rst = 1'b1;
    in_valid = 1'b0;
    op = OP_ADD;
    size = SZ64;
    cond = CC_AL;
    a = '0;
    b = '0;
    flags_in = '0;
    repeat (16)
    begin
      @(negedge clk);
      check_bit(out_valid, 1'b0, "out_valid in reset");
    end
    rst = 1'b0;
    @(negedge clk);
    check_bit(out_valid, 1'b0, "out_valid after reset");
    check_word(result, '0, "result after reset");
    check_flags(flags_out, '0, "flags_out after reset");
    check_bit(flags_we, 1'b0, "flags_we after reset");

    fill_vectors();
    foreach (vec_q[i])
      apply_vec(vec_q[i], CC_AL, $sformatf("row %0d", i));

    // each condition once true and once false
    for (int c = 0; c < 16; c++)
    begin
      for (int t = 0; t < 2; t++)
      begin
        tk = (t == 0) || (c == 15);
        v.size = SZ64;
        v.a = 64'h0123_4567_89AB_CDEF;
        v.b = 64'hFEDC_BA98_7654_3210;
        v.fin = (t == 0) ? COND_TRUE[c] : COND_FALSE[c];
        v.exp_flags = v.fin;
        v.exp_we = 1'b0;
        v.op = OP_CMOV;
        v.exp_res = tk ? v.b : v.a;
        apply_vec(v, cond_e'(c), $sformatf("cmov cc %0d", c));
        v.op = OP_CSET;
        v.exp_res = {63'b0, tk};
        apply_vec(v, cond_e'(c), $sformatf("cset cc %0d", c));
      end
    end

    for (int i = 0; i < 200; i++)
    begin
      v.op = ($urandom() % 2) ? OP_SUB : OP_ADD;
      v.size = op_size_e'($urandom() % 4);
      v.a = {$urandom(), $urandom()};
      v.b = {$urandom(), $urandom()};
      v.fin = '0;
      v.exp_we = 1'b1;
      arith_model(v.op, v.size, v.a, v.b, v.exp_res, v.exp_flags);
      apply_vec(v, CC_AL, $sformatf("random %0d", i));
    end

    // burst of eight, results on consecutive cycles
    for (int i = 0; i < 8; i++)
    begin
      burst[i].op = OP_ADD;
      burst[i].size = SZ64;
      burst[i].a = {$urandom(), $urandom()};
      burst[i].b = {$urandom(), $urandom()};
      arith_model(OP_ADD, SZ64, burst[i].a, burst[i].b, burst[i].exp_res, burst[i].exp_flags);
    end
    for (int i = 0; i <= 8; i++)
    begin
      @(negedge clk);
      if (i > 0)
      begin
        check_bit(out_valid, 1'b1, $sformatf("burst out_valid %0d", i - 1));
        check_word(result, burst[i-1].exp_res, $sformatf("burst result %0d", i - 1));
        check_flags(flags_out, burst[i-1].exp_flags, $sformatf("burst flags %0d", i - 1));
        check_bit(flags_we, 1'b1, $sformatf("burst flags_we %0d", i - 1));
      end
      in_valid = (i < 8);
      if (i < 8)
      begin
        op = OP_ADD;
        size = SZ64;
        a = burst[i].a;
        b = burst[i].b;
      end
    end
    repeat (3)
    begin
      @(negedge clk);
      check_bit(out_valid, 1'b0, "out_valid idle");
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
